/* verilog/lsq_pkg.sv */
// Load/store queue package with shared widths, ID count and the address hash rule
package lsq_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Request ID space, also the default load queue depth
    localparam int unsigned ID_COUNT = 8;

    // Hash used for load/store alias checks
    localparam int unsigned HASH_W = 5;

    // Byte address of a request
    typedef logic [31:0] addr_t;

    // Store data and its byte enables
    typedef logic [31:0] data_t;
    typedef logic [3:0] be_t;

    // Access size and sign, passed through untouched
    typedef logic [2:0] fn3_t;

    typedef logic [$clog2(ID_COUNT)-1:0] id_t;
    typedef logic [HASH_W-1:0] hash_t;

    //////////////////////////////
    // Hash rule
    //////////////////////////////

    // Word granularity, so bits 1..0 play no part
    // Equal hashes are treated as a possible alias
    function automatic hash_t addr_hash(input addr_t addr);
        hash_t lo;
        hash_t hi;
        lo = addr[6:2];
        hi = addr[11:7];
        return lo ^ hi;
    endfunction

endpackage

/* verilog/lsq_entry_if.sv */
// Request entry bus from the intake stage to the load and store queues
`timescale 1ns/1ps

interface lsq_entry_if #(
    parameter int unsigned SQ_DEPTH = 4
);

    // One-cycle write strobes, never both high
    logic push_load;
    logic push_store;

    // Registered request fields
    lsq_pkg::addr_t addr;
    lsq_pkg::hash_t hash;
    lsq_pkg::fn3_t fn3;
    lsq_pkg::id_t id;
    lsq_pkg::data_t data;
    lsq_pkg::be_t be;

    // Store slots a load may alias, one bit per store queue slot
    logic [SQ_DEPTH-1:0] conflicts;

    // Intake side
    modport source (
        output push_load, push_store, addr, hash, fn3, id, data, be, conflicts
    );

    // Queue side
    modport sink (
        input push_load, push_store, addr, hash, fn3, id, data, be, conflicts
    );

endinterface

/* verilog/lsq_intake.sv */
// Intake stage that registers a request, hashes its address and raises full
`timescale 1ns/1ps

module lsq_intake #(
    parameter int unsigned SQ_DEPTH = 4,
    parameter int unsigned LQ_DEPTH = lsq_pkg::ID_COUNT
) (
    input logic clk,
    input logic rst_n,

    // Request side
    input logic push,
    input logic store,
    input lsq_pkg::addr_t addr,
    input lsq_pkg::fn3_t fn3,
    input lsq_pkg::id_t id,
    input lsq_pkg::data_t data,
    input lsq_pkg::be_t be,

    // Queue occupancy
    input logic [$clog2(SQ_DEPTH+1)-1:0] sq_count,
    input logic [$clog2(LQ_DEPTH+1)-1:0] lq_count,

    // Store queue lookup result for the registered hash
    input logic [SQ_DEPTH-1:0] match,

    output logic full,
    lsq_entry_if.source entry
);

    localparam int unsigned SQ_CW = $clog2(SQ_DEPTH + 1);
    localparam int unsigned LQ_CW = $clog2(LQ_DEPTH + 1);

    logic sq_near_full;
    logic lq_near_full;
    logic sq_at_full;
    logic lq_at_full;

    //////////////////////////////
    // Intake register
    //////////////////////////////

    // Strobes follow push every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry.push_load <= 1'b0;
            entry.push_store <= 1'b0;
        end else begin
            entry.push_load <= push & ~store;
            entry.push_store <= push & store;
        end
    end

    // Payload only moves on a push
    always_ff @(posedge clk) begin
        if (push) begin
            entry.addr <= addr;
            entry.hash <= lsq_pkg::addr_hash(addr);
            entry.fn3 <= fn3;
            entry.id <= id;
            entry.data <= data;
            entry.be <= be;
        end
    end

    // Loads take a snapshot of every queued store with the same hash
    // Taken while the load sits here, so all older stores are already queued
    assign entry.conflicts = entry.push_load ? match : '0;

    //////////////////////////////
    // Full
    //////////////////////////////

    // Last free slot already claimed by the entry held here
    assign sq_near_full = entry.push_store & (sq_count >= SQ_CW'(SQ_DEPTH - 1));
    assign lq_near_full = entry.push_load & (lq_count >= LQ_CW'(LQ_DEPTH - 1));

    // Either queue full right now
    assign sq_at_full = (sq_count == SQ_CW'(SQ_DEPTH));
    assign lq_at_full = (lq_count == LQ_CW'(LQ_DEPTH));

    assign full = sq_near_full | lq_near_full | sq_at_full | lq_at_full;

    // Source must respect back-pressure
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    ) else $error("push while full");

endmodule

/* verilog/store_queue.sv */
// Store queue, a circular buffer whose stores wait for retire before issue
`timescale 1ns/1ps

module store_queue #(
    parameter int unsigned SQ_DEPTH = 4
) (
    input logic clk,
    input logic rst_n,

    lsq_entry_if.sink entry,

    // Alias lookup for a load in the intake register
    input lsq_pkg::hash_t lookup_hash,
    output logic [SQ_DEPTH-1:0] match,

    // Retire release
    input logic retire_valid,
    input lsq_pkg::id_t retire_id,

    // Issue side
    input logic store_pop,
    output logic store_valid,
    output logic sq_full,
    output logic sq_empty,
    output logic [$clog2(SQ_DEPTH+1)-1:0] count,
    output lsq_pkg::addr_t head_addr,
    output lsq_pkg::data_t head_data,
    output lsq_pkg::be_t head_be,
    output lsq_pkg::fn3_t head_fn3,
    output lsq_pkg::id_t head_id,

    // Freed slot, clears load conflict bits
    output logic store_popped,
    output logic [((SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1)-1:0] popped_slot
);

    localparam int unsigned PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(SQ_DEPTH + 1);

    // Slot control
    logic [SQ_DEPTH-1:0] valid;
    logic [SQ_DEPTH-1:0] released;
    logic [SQ_DEPTH-1:0] retire_hit;

    // Slot payload
    lsq_pkg::hash_t slot_hash [SQ_DEPTH];
    lsq_pkg::addr_t slot_addr [SQ_DEPTH];
    lsq_pkg::data_t slot_data [SQ_DEPTH];
    lsq_pkg::be_t slot_be [SQ_DEPTH];
    lsq_pkg::fn3_t slot_fn3 [SQ_DEPTH];
    lsq_pkg::id_t slot_id [SQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic push_retired;

    //////////////////////////////
    // Retire and lookup
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            retire_hit[i] = retire_valid & valid[i] & (slot_id[i] == retire_id);
            // Any occupied slot counts, released or not
            match[i] = valid[i] & (slot_hash[i] == lookup_hash);
        end
    end

    // Retire that lands while the store is still in the intake register
    assign push_retired = retire_valid & (entry.id == retire_id);

    //////////////////////////////
    // Pointers and slot control
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            released <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (retire_hit[i])
                    released[i] <= 1'b1;
            end
            if (entry.push_store) begin
                valid[tail] <= 1'b1;
                released[tail] <= push_retired;
                tail <= (tail == PTR_W'(SQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            // Head only, in program order
            if (store_pop) begin
                valid[head] <= 1'b0;
                released[head] <= 1'b0;
                head <= (head == PTR_W'(SQ_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({entry.push_store, store_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Slot payload written at the tail
    always_ff @(posedge clk) begin
        if (entry.push_store) begin
            slot_hash[tail] <= entry.hash;
            slot_addr[tail] <= entry.addr;
            slot_data[tail] <= entry.data;
            slot_be[tail] <= entry.be;
            slot_fn3[tail] <= entry.fn3;
            slot_id[tail] <= entry.id;
        end
    end

    //////////////////////////////
    // Head outputs
    //////////////////////////////

    assign store_valid = valid[head] & released[head];
    assign sq_full = (count == CNT_W'(SQ_DEPTH));
    assign sq_empty = (count == '0);

    assign head_addr = slot_addr[head];
    assign head_data = slot_data[head];
    assign head_be = slot_be[head];
    assign head_fn3 = slot_fn3[head];
    assign head_id = slot_id[head];

    assign store_popped = store_pop;
    assign popped_slot = head;

    // Issue stage must never take an unretired store
    a_pop_released : assert property (
        @(posedge clk) disable iff (!rst_n) store_pop |-> valid[head] && released[head]
    ) else $error("store popped before release");

    // Intake full must hold back a store the queue cannot take
    a_push_not_full : assert property (
        @(posedge clk) disable iff (!rst_n) entry.push_store |-> !sq_full
    ) else $error("store pushed into full queue");

endmodule

/* verilog/load_queue.sv */
// Load queue, an in-order FIFO whose entries wait on their store conflicts
`timescale 1ns/1ps

module load_queue #(
    parameter int unsigned SQ_DEPTH = 4,
    parameter int unsigned LQ_DEPTH = lsq_pkg::ID_COUNT
) (
    input logic clk,
    input logic rst_n,

    lsq_entry_if.sink entry,

    // Store leaving the store queue
    input logic store_popped,
    input logic [((SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1)-1:0] popped_slot,

    // Issue side
    input logic load_pop,
    output logic load_valid,
    output logic lq_empty,
    output logic [$clog2(LQ_DEPTH+1)-1:0] count,
    output lsq_pkg::addr_t head_addr,
    output lsq_pkg::fn3_t head_fn3,
    output lsq_pkg::id_t head_id
);

    localparam int unsigned PTR_W = (LQ_DEPTH > 1) ? $clog2(LQ_DEPTH) : 1;

    // Per-entry store conflicts, only ever clear once written
    logic [SQ_DEPTH-1:0] conflicts [LQ_DEPTH];
    logic [SQ_DEPTH-1:0] clear_mask;

    // Entry payload
    lsq_pkg::addr_t lq_addr [LQ_DEPTH];
    lsq_pkg::fn3_t lq_fn3 [LQ_DEPTH];
    lsq_pkg::id_t lq_id [LQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    // Bit of the slot freed this cycle
    assign clear_mask = store_popped ? (SQ_DEPTH'(1) << popped_slot) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LQ_DEPTH; i++)
                conflicts[i] <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++)
                conflicts[i] <= conflicts[i] & ~clear_mask;
            // New load also drops a store leaving in the same cycle
            if (entry.push_load) begin
                conflicts[tail] <= entry.conflicts & ~clear_mask;
                tail <= (tail == PTR_W'(LQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (load_pop)
                head <= (head == PTR_W'(LQ_DEPTH - 1)) ? '0 : head + 1'b1;
            case ({entry.push_load, load_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (entry.push_load) begin
            lq_addr[tail] <= entry.addr;
            lq_fn3[tail] <= entry.fn3;
            lq_id[tail] <= entry.id;
        end
    end

    // Head ready once every aliasing store is gone
    assign lq_empty = (count == '0);
    assign load_valid = ~lq_empty & ~|conflicts[head];

    assign head_addr = lq_addr[head];
    assign head_fn3 = lq_fn3[head];
    assign head_id = lq_id[head];

    // Issue stage takes only a ready head
    a_pop_valid : assert property (
        @(posedge clk) disable iff (!rst_n) load_pop |-> load_valid
    ) else $error("load popped while not valid");

endmodule

/* verilog/lsq_issue.sv */
// Issue stage that picks a load or a store for the memory port
`timescale 1ns/1ps

module lsq_issue (
    input logic clk,
    input logic rst_n,

    // Queue status
    input logic load_valid,
    input logic store_valid,
    input logic sq_full,

    // Load head
    input lsq_pkg::addr_t load_addr,
    input lsq_pkg::fn3_t load_fn3,
    input lsq_pkg::id_t load_id,

    // Store head
    input lsq_pkg::addr_t store_addr,
    input lsq_pkg::data_t store_data,
    input lsq_pkg::be_t store_be,
    input lsq_pkg::fn3_t store_fn3,
    input lsq_pkg::id_t store_id,

    input logic issue_ack,
    output logic load_pop,
    output logic store_pop,

    // Memory side
    output logic issue_valid,
    output logic issue_store,
    output lsq_pkg::addr_t issue_addr,
    output lsq_pkg::fn3_t issue_fn3,
    output lsq_pkg::id_t issue_id,
    output lsq_pkg::data_t issue_data,
    output lsq_pkg::be_t issue_be
);

    logic sel_store;

    // Loads first, unless a full store queue needs draining
    assign sel_store = store_valid & (~load_valid | sq_full);

    assign issue_valid = load_valid | store_valid;
    assign issue_store = sel_store;

    assign issue_addr = sel_store ? store_addr : load_addr;
    assign issue_fn3 = sel_store ? store_fn3 : load_fn3;
    assign issue_id = sel_store ? store_id : load_id;

    // No payload on a load
    assign issue_data = sel_store ? store_data : '0;
    assign issue_be = sel_store ? store_be : '0;

    // Ack pops whichever head was shown
    assign load_pop = issue_ack & ~sel_store;
    assign store_pop = issue_ack & sel_store;

    // Memory side acks only an offered operation
    a_ack_with_valid : assert property (
        @(posedge clk) disable iff (!rst_n) issue_ack |-> issue_valid
    ) else $error("issue_ack without issue_valid");

endmodule

/* verilog/lsq_top.sv */
// Load/store queue top level joining intake, both queues and issue
`timescale 1ns/1ps

module lsq_top #(
    parameter int unsigned SQ_DEPTH = 4,
    parameter int unsigned LQ_DEPTH = lsq_pkg::ID_COUNT
) (
    input logic clk,
    input logic rst_n,

    // Request side
    input logic push,
    input logic store,
    input lsq_pkg::addr_t addr,
    input lsq_pkg::fn3_t fn3,
    input lsq_pkg::id_t id,
    input lsq_pkg::data_t data,
    input lsq_pkg::be_t be,
    output logic full,

    // Retire
    input logic retire_valid,
    input lsq_pkg::id_t retire_id,

    // Memory side
    input logic issue_ack,
    output logic issue_valid,
    output logic issue_store,
    output lsq_pkg::addr_t issue_addr,
    output lsq_pkg::fn3_t issue_fn3,
    output lsq_pkg::id_t issue_id,
    output lsq_pkg::data_t issue_data,
    output lsq_pkg::be_t issue_be,
    output logic empty
);

    localparam int unsigned SQ_PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;

    lsq_entry_if #(.SQ_DEPTH(SQ_DEPTH)) entry_bus ();

    // Store queue status and head
    logic [SQ_DEPTH-1:0] match;
    logic [$clog2(SQ_DEPTH+1)-1:0] sq_count;
    logic store_valid, sq_full, sq_empty, store_pop, store_popped;
    logic [SQ_PTR_W-1:0] popped_slot;
    lsq_pkg::addr_t sq_addr;
    lsq_pkg::data_t sq_data;
    lsq_pkg::be_t sq_be;
    lsq_pkg::fn3_t sq_fn3;
    lsq_pkg::id_t sq_id;

    // Load queue status and head
    logic [$clog2(LQ_DEPTH+1)-1:0] lq_count;
    logic load_valid, lq_empty, load_pop;
    lsq_pkg::addr_t lq_addr;
    lsq_pkg::fn3_t lq_fn3;
    lsq_pkg::id_t lq_id;

    //////////////////////////////
    // Stages
    //////////////////////////////

    lsq_intake #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) i_intake (
        .clk(clk), .rst_n(rst_n), .push(push), .store(store), .addr(addr), .fn3(fn3),
        .id(id), .data(data), .be(be), .sq_count(sq_count), .lq_count(lq_count),
        .match(match), .full(full), .entry(entry_bus.source)
    );

    // Lookup uses the hash held in the intake register
    store_queue #(.SQ_DEPTH(SQ_DEPTH)) i_store_queue (
        .clk(clk), .rst_n(rst_n), .entry(entry_bus.sink), .lookup_hash(entry_bus.hash),
        .match(match), .retire_valid(retire_valid), .retire_id(retire_id),
        .store_pop(store_pop), .store_valid(store_valid), .sq_full(sq_full),
        .sq_empty(sq_empty), .count(sq_count), .head_addr(sq_addr), .head_data(sq_data),
        .head_be(sq_be), .head_fn3(sq_fn3), .head_id(sq_id),
        .store_popped(store_popped), .popped_slot(popped_slot)
    );

    load_queue #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) i_load_queue (
        .clk(clk), .rst_n(rst_n), .entry(entry_bus.sink), .store_popped(store_popped),
        .popped_slot(popped_slot), .load_pop(load_pop), .load_valid(load_valid),
        .lq_empty(lq_empty), .count(lq_count), .head_addr(lq_addr), .head_fn3(lq_fn3),
        .head_id(lq_id)
    );

    lsq_issue i_issue (
        .clk(clk), .rst_n(rst_n), .load_valid(load_valid), .store_valid(store_valid),
        .sq_full(sq_full), .load_addr(lq_addr), .load_fn3(lq_fn3), .load_id(lq_id),
        .store_addr(sq_addr), .store_data(sq_data), .store_be(sq_be), .store_fn3(sq_fn3),
        .store_id(sq_id), .issue_ack(issue_ack), .load_pop(load_pop), .store_pop(store_pop),
        .issue_valid(issue_valid), .issue_store(issue_store), .issue_addr(issue_addr),
        .issue_fn3(issue_fn3), .issue_id(issue_id), .issue_data(issue_data),
        .issue_be(issue_be)
    );

    // Nothing queued and nothing in the intake register
    assign empty = lq_empty & sq_empty & ~(entry_bus.push_load | entry_bus.push_store);

endmodule

/* tests/lsq_tb.sv */
// Testbench for the load/store queue, a table of cycles checked against the issue port
`timescale 1ns/1ps

module lsq_tb;

    localparam int RESET_CYCLES = 16;
    localparam lsq_pkg::fn3_t LOAD_FN3 = 3'b100;
    localparam lsq_pkg::fn3_t STORE_FN3 = 3'b010;

    // One cycle of stimulus, plus the outputs expected just before it is driven
    typedef struct packed {
        logic push;
        logic store;
        lsq_pkg::addr_t addr;
        lsq_pkg::id_t id;
        lsq_pkg::data_t data;
        lsq_pkg::be_t be;
        logic retire;
        lsq_pkg::id_t retire_id;
        logic ack;
        logic exp_valid;
        logic exp_store;
        lsq_pkg::addr_t exp_addr;
        lsq_pkg::id_t exp_id;
        lsq_pkg::data_t exp_data;
        lsq_pkg::be_t exp_be;
        logic exp_full;
        logic exp_empty;
    } row_t;

    logic clk;
    logic rst_n;
    logic push;
    logic store;
    lsq_pkg::addr_t addr;
    lsq_pkg::fn3_t fn3;
    lsq_pkg::id_t id;
    lsq_pkg::data_t data;
    lsq_pkg::be_t be;
    logic retire_valid;
    lsq_pkg::id_t retire_id;
    logic issue_ack;
    logic full;
    logic issue_valid;
    logic issue_store;
    lsq_pkg::addr_t issue_addr;
    lsq_pkg::fn3_t issue_fn3;
    lsq_pkg::id_t issue_id;
    lsq_pkg::data_t issue_data;
    lsq_pkg::be_t issue_be;
    logic empty;

    row_t rows[$];
    row_t cur;
    logic [15:0] lfsr_state = 16'd12;
    int cycles = 0;
    int cycle_limit = 0;
    int errors = 0;

    lsq_top i_lsq_top (
        .clk(clk), .rst_n(rst_n), .push(push), .store(store), .addr(addr), .fn3(fn3),
        .id(id), .data(data), .be(be), .full(full), .retire_valid(retire_valid),
        .retire_id(retire_id), .issue_ack(issue_ack), .issue_valid(issue_valid),
        .issue_store(issue_store), .issue_addr(issue_addr), .issue_fn3(issue_fn3),
        .issue_id(issue_id), .issue_data(issue_data), .issue_be(issue_be), .empty(empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Random bits
    //////////////////////////////

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    //////////////////////////////
    // Failure handling
    //////////////////////////////

    task automatic end_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end_with_failure();
    endtask

    // Stimulus sanity, equal hash means possible alias
    task automatic check_hash(input lsq_pkg::addr_t a, input lsq_pkg::addr_t b,
                              input logic same);
        assert ((lsq_pkg::addr_hash(a) == lsq_pkg::addr_hash(b)) == same) else begin
            $display("Stimulus error: addresses %h and %h lack the intended hash relation",
                     a, b);
            end_with_failure();
        end
    endtask

    //////////////////////////////
    // Table building
    //////////////////////////////

    task automatic queue_request(input logic st, input lsq_pkg::addr_t a,
                                 input lsq_pkg::id_t i, input lsq_pkg::data_t d,
                                 input lsq_pkg::be_t b);
        cur.push = 1'b1;
        cur.store = st;
        cur.addr = a;
        cur.id = i;
        cur.data = d;
        cur.be = b;
    endtask

    task automatic retire_store(input lsq_pkg::id_t i);
        cur.retire = 1'b1;
        cur.retire_id = i;
    endtask

    // Loads carry no data or byte enables on the port
    task automatic expect_load(input lsq_pkg::addr_t a, input lsq_pkg::id_t i);
        cur.exp_valid = 1'b1;
        cur.exp_store = 1'b0;
        cur.exp_addr = a;
        cur.exp_id = i;
        cur.exp_data = '0;
        cur.exp_be = '0;
    endtask

    task automatic expect_store(input lsq_pkg::addr_t a, input lsq_pkg::id_t i,
                                input lsq_pkg::data_t d, input lsq_pkg::be_t b);
        cur.exp_valid = 1'b1;
        cur.exp_store = 1'b1;
        cur.exp_addr = a;
        cur.exp_id = i;
        cur.exp_data = d;
        cur.exp_be = b;
    endtask

    task automatic end_row(input logic ack, input logic f, input logic e);
        cur.ack = ack;
        cur.exp_full = f;
        cur.exp_empty = e;
        rows.push_back(cur);
        cur = '0;
    endtask

    task automatic build_table();
        lsq_pkg::addr_t ld_a;
        lsq_pkg::addr_t ld_b;
        lsq_pkg::addr_t ld_c;
        lsq_pkg::addr_t ld_d;
        lsq_pkg::addr_t fill_addr [4];
        lsq_pkg::data_t fill_data [4];
        lsq_pkg::data_t d2;
        lsq_pkg::data_t d3;
        lsq_pkg::data_t d6;
        // Stores hash to 16, the alias load too, other loads to 3 or 6
        ld_a = 32'h0000_2104 | random_bits(2);
        ld_b = 32'h0000_2208 | random_bits(2);
        ld_c = 32'h0000_2104 | random_bits(2);
        ld_d = 32'h0000_2104 | random_bits(2);
        d2 = random_bits(32);
        d3 = random_bits(32);
        d6 = random_bits(32);
        for (int k = 0; k < 4; k++) begin
            fill_addr[k] = 32'h0001_0040 | (k << 12);
            fill_data[k] = random_bits(32);
            check_hash(fill_addr[k], ld_d, 1'b0);
        end
        check_hash(32'h0000_3040, 32'h0000_2800, 1'b1);
        check_hash(32'h0000_3040, ld_b, 1'b0);
        check_hash(32'h0000_4040, ld_c, 1'b0);

        // Lone load, two cycles from push to issue
        queue_request(1'b0, ld_a, 3'd1, '0, '0);
        end_row(1'b0, 1'b0, 1'b1);
        end_row(1'b0, 1'b0, 1'b0);
        expect_load(ld_a, 3'd1);
        end_row(1'b1, 1'b0, 1'b0);

        // Store stays hidden on an idle port until retired
        queue_request(1'b1, 32'h0000_2040, 3'd2, d2, 4'hf);
        end_row(1'b0, 1'b0, 1'b1);
        end_row(1'b0, 1'b0, 1'b0);
        end_row(1'b0, 1'b0, 1'b0);
        retire_store(3'd2);
        end_row(1'b0, 1'b0, 1'b0);
        expect_store(32'h0000_2040, 3'd2, d2, 4'hf);
        end_row(1'b1, 1'b0, 1'b0);

        // Alias load blocked by an older store, younger load stuck behind it
        queue_request(1'b1, 32'h0000_3040, 3'd3, d3, 4'h3);
        end_row(1'b0, 1'b0, 1'b1);
        queue_request(1'b0, 32'h0000_2800, 3'd4, '0, '0);
        end_row(1'b0, 1'b0, 1'b0);
        queue_request(1'b0, ld_b, 3'd5, '0, '0);
        end_row(1'b0, 1'b0, 1'b0);
        end_row(1'b0, 1'b0, 1'b0);
        end_row(1'b0, 1'b0, 1'b0);
        retire_store(3'd3);
        end_row(1'b0, 1'b0, 1'b0);
        expect_store(32'h0000_3040, 3'd3, d3, 4'h3);
        end_row(1'b1, 1'b0, 1'b0);
        expect_load(32'h0000_2800, 3'd4);
        end_row(1'b1, 1'b0, 1'b0);
        expect_load(ld_b, 3'd5);
        end_row(1'b1, 1'b0, 1'b0);

        // Unaliased load takes the port from an older released store
        queue_request(1'b1, 32'h0000_4040, 3'd6, d6, 4'hc);
        end_row(1'b0, 1'b0, 1'b1);
        queue_request(1'b0, ld_c, 3'd7, '0, '0);
        // Retire lands while the store is still in the intake register
        retire_store(3'd6);
        end_row(1'b0, 1'b0, 1'b0);
        expect_store(32'h0000_4040, 3'd6, d6, 4'hc);
        end_row(1'b0, 1'b0, 1'b0);
        expect_load(ld_c, 3'd7);
        end_row(1'b1, 1'b0, 1'b0);
        expect_store(32'h0000_4040, 3'd6, d6, 4'hc);
        end_row(1'b1, 1'b0, 1'b0);

        // Fill the store queue with one load slipped in
        for (int k = 0; k < 3; k++) begin
            queue_request(1'b1, fill_addr[k], lsq_pkg::id_t'(k), fill_data[k], 4'h1 << k);
            end_row(1'b0, 1'b0, k == 0);
        end
        queue_request(1'b0, ld_d, 3'd4, '0, '0);
        end_row(1'b0, 1'b0, 1'b0);
        queue_request(1'b1, fill_addr[3], 3'd3, fill_data[3], 4'h8);
        end_row(1'b0, 1'b0, 1'b0);
        // Load held without ack, fields frozen, while stores retire youngest first
        for (int k = 3; k >= 0; k--) begin
            expect_load(ld_d, 3'd4);
            retire_store(lsq_pkg::id_t'(k));
            end_row(1'b0, 1'b1, 1'b0);
        end
        // Full store queue wins, one ack drops full
        expect_store(fill_addr[0], 3'd0, fill_data[0], 4'h1);
        end_row(1'b1, 1'b1, 1'b0);
        expect_load(ld_d, 3'd4);
        end_row(1'b1, 1'b0, 1'b0);
        for (int k = 1; k < 4; k++) begin
            expect_store(fill_addr[k], lsq_pkg::id_t'(k), fill_data[k], 4'h1 << k);
            end_row(1'b1, 1'b0, 1'b0);
        end
        end_row(1'b0, 1'b0, 1'b1);
    endtask

    //////////////////////////////
    // Apply and check
    //////////////////////////////

    task automatic check_row(input int r, input row_t e);
        assert (issue_valid === e.exp_valid)
            else report_mismatch($sformatf("row %0d issue_valid", r), issue_valid, e.exp_valid);
        assert (full === e.exp_full)
            else report_mismatch($sformatf("row %0d full", r), full, e.exp_full);
        assert (empty === e.exp_empty)
            else report_mismatch($sformatf("row %0d empty", r), empty, e.exp_empty);
        if (e.exp_valid) begin
            assert (issue_store === e.exp_store)
                else report_mismatch($sformatf("row %0d issue_store", r), issue_store,
                                     e.exp_store);
            assert (issue_addr === e.exp_addr)
                else report_mismatch($sformatf("row %0d issue_addr", r), issue_addr,
                                     e.exp_addr);
            assert (issue_id === e.exp_id)
                else report_mismatch($sformatf("row %0d issue_id", r), issue_id, e.exp_id);
            assert (issue_fn3 === (e.exp_store ? STORE_FN3 : LOAD_FN3))
                else report_mismatch($sformatf("row %0d issue_fn3", r), issue_fn3,
                                     e.exp_store ? STORE_FN3 : LOAD_FN3);
            assert (issue_data === e.exp_data)
                else report_mismatch($sformatf("row %0d issue_data", r), issue_data,
                                     e.exp_data);
            assert (issue_be === e.exp_be)
                else report_mismatch($sformatf("row %0d issue_be", r), issue_be, e.exp_be);
        end
    endtask

    task automatic drive_row(input row_t e);
        push = e.push;
        store = e.store;
        addr = e.addr;
        fn3 = e.store ? STORE_FN3 : LOAD_FN3;
        id = e.id;
        data = e.data;
        be = e.be;
        retire_valid = e.retire;
        retire_id = e.retire_id;
        issue_ack = e.ack;
    endtask

    // Guard against a stalled run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            end_with_failure();
        end
    end

    initial begin
        rst_n = 1'b0;
        push = 1'b0;
        store = 1'b0;
        addr = '0;
        fn3 = '0;
        id = '0;
        data = '0;
        be = '0;
        retire_valid = 1'b0;
        retire_id = '0;
        issue_ack = 1'b0;
        cur = '0;
        build_table();
        cycle_limit = 8 * rows.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Check the state left by the last edge, then drive the next cycle
        for (int r = 0; r < rows.size(); r++) begin
            @(negedge clk);
            check_row(r, rows[r]);
            drive_row(rows[r]);
        end
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

/* src.f */
verilog/lsq_pkg.sv
verilog/lsq_entry_if.sv
verilog/lsq_intake.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/lsq_issue.sv
verilog/lsq_top.sv
tests/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - verilog/lsq_pkg.sv
  - verilog/lsq_entry_if.sv
  - verilog/lsq_intake.sv
  - verilog/store_queue.sv
  - verilog/load_queue.sv
  - verilog/lsq_issue.sv
  - verilog/lsq_top.sv
  - target: test
    files:
      - tests/lsq_tb.sv
